/* Bender.yml */
package:
  name: exe_stage

sources:
  - files:
      - hw/exe_pkg.sv
      - hw/exe_alu.sv
      - hw/exe_muldiv.sv
      - hw/exe_store_align.sv
      - hw/exe_stage.sv
  - target: simulation
    files:
      - sim/exe_checker.sv
      - sim/exe_tb.sv

/* hw/exe_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_alu import exe_pkg::*; (
    input  alu_op_e           op,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic [data_w-1:0] result,
    output logic              overflow
);

    logic [data_w-1:0] sum;
    logic [data_w-1:0] diff;
    logic [4:0]        shamt;
    logic              add_ovf;
    logic              sub_ovf;
    logic              lt_signed;
    logic              lt_unsigned;

    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = a[4:0];

    // same-sign operands, result sign flipped
    assign add_ovf = (a[data_w-1] == b[data_w-1]) && (sum[data_w-1] != a[data_w-1]);
    // subtrahend of opposite sign
    assign sub_ovf = (a[data_w-1] != b[data_w-1]) && (diff[data_w-1] != a[data_w-1]);

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  overflow = add_ovf;
            alu_sub:  overflow = sub_ovf;
            default:  overflow = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            alu_add, alu_addu: begin
                result = sum;
            end
            alu_sub, alu_subu: begin
                result = diff;
            end
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_nor:  result = ~(a | b);
            alu_slt:  result = {{(data_w - 1){1'b0}}, lt_signed};
            alu_sltu: result = {{(data_w - 1){1'b0}}, lt_unsigned};
            alu_sll:  result = b << shamt;
            alu_srl:  result = b >> shamt;
            alu_sra:  result = $signed(b) >>> shamt;
            alu_lui:  result = {b[15:0], 16'h0000};
            // mul/div and hi/lo moves are resolved outside
            default:  result = sum;
        endcase
    end

endmodule

`default_nettype wire

/* hw/exe_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_muldiv import exe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              commit,
    input  alu_op_e           op,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic              busy,
    output logic [data_w-1:0] hi,
    output logic [data_w-1:0] lo
);

    logic signed [2*data_w-1:0] prod_s;
    logic [2*data_w-1:0]        prod_u;
    logic [data_w-1:0]          pend_hi;
    logic [data_w-1:0]          pend_lo;
    logic [data_w-1:0]          a_mag;
    logic [data_w-1:0]          b_mag;
    logic [data_w-1:0]          quot;
    logic [data_w-1:0]          rem;
    logic [data_w-1:0]          divisor;
    logic [data_w:0]            rem_shift;
    logic [data_w:0]            trial;
    logic [div_cnt_w-1:0]       step;
    logic                       signed_div;
    logic                       is_div;
    logic                       last_step;
    logic                       neg_q;
    logic                       neg_r;

    assign prod_s = $signed(a) * $signed(b);
    assign prod_u = a * b;

    assign is_div     = (op == alu_div) || (op == alu_divu);
    assign signed_div = (op == alu_div);

    // divide on magnitudes, signs restored at the end
    assign a_mag = (signed_div && a[data_w-1]) ? ~a + 1'b1 : a;
    assign b_mag = (signed_div && b[data_w-1]) ? ~b + 1'b1 : b;

    // restoring step: shift in next dividend bit, try subtract
    assign rem_shift = {rem, quot[data_w-1]};
    assign trial     = rem_shift - {1'b0, divisor};
    assign last_step = (step == div_cnt_w'(div_steps));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            step <= '0;
        end else if (start && is_div) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            if (last_step) begin
                busy <= 1'b0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && is_div) begin
            quot    <= a_mag;
            divisor <= b_mag;
            rem     <= '0;
            neg_q   <= signed_div && (a[data_w-1] ^ b[data_w-1]);
            neg_r   <= signed_div && a[data_w-1];
        end else if (busy && !last_step) begin
            quot <= {quot[data_w-2:0], ~trial[data_w]};
            rem  <= trial[data_w] ? rem_shift[data_w-1:0] : trial[data_w-1:0];
        end
    end

    // pending pair mirrors what hi/lo become at the next commit
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_hi <= '0;
            pend_lo <= '0;
        end else if (start) begin
            case (op)
                alu_mult:  {pend_hi, pend_lo} <= prod_s;
                alu_multu: {pend_hi, pend_lo} <= prod_u;
                alu_mthi:  pend_hi <= a;
                alu_mtlo:  pend_lo <= a;
                default:   ;
            endcase
        end else if (busy && last_step) begin
            pend_lo <= neg_q ? ~quot + 1'b1 : quot;
            pend_hi <= neg_r ? ~rem + 1'b1 : rem;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            hi <= pend_hi;
            lo <= pend_lo;
        end
    end

    // top must hold the stage while a division runs
    assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

`default_nettype wire

/* hw/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    localparam int data_w = 32;

    // divider iterations, one quotient bit each
    localparam int div_steps = 32;
    localparam int div_cnt_w = $clog2(div_steps + 1);

    // kseg0/kseg1 fold onto physical low 512 MB
    localparam logic [data_w-1:0] kseg_mask = 32'h1fff_ffff;

    // memory size codes
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    typedef enum logic [4:0] {
        alu_add   = 5'd0,
        alu_addu  = 5'd1,
        alu_sub   = 5'd2,
        alu_subu  = 5'd3,
        alu_and   = 5'd4,
        alu_or    = 5'd5,
        alu_xor   = 5'd6,
        alu_nor   = 5'd7,
        alu_slt   = 5'd8,
        alu_sltu  = 5'd9,
        alu_sll   = 5'd10,
        alu_srl   = 5'd11,
        alu_sra   = 5'd12,
        alu_lui   = 5'd13,
        alu_mult  = 5'd14,
        alu_multu = 5'd15,
        alu_div   = 5'd16,
        alu_divu  = 5'd17,
        alu_mfhi  = 5'd18,
        alu_mflo  = 5'd19,
        alu_mthi  = 5'd20,
        alu_mtlo  = 5'd21
    } alu_op_e;

    typedef enum logic [2:0] {
        mem_none        = 3'd0,
        mem_load_word   = 3'd1,
        mem_store_byte  = 3'd2,
        mem_store_half  = 3'd3,
        mem_store_word  = 3'd4,
        mem_store_left  = 3'd5,
        mem_store_right = 3'd6
    } mem_op_e;

endpackage

`default_nettype wire

/* hw/exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_stage import exe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_allowin,
    input  alu_op_e           in_op,
    input  mem_op_e           in_mem_op,
    input  logic [data_w-1:0] in_rs,
    input  logic [data_w-1:0] in_rt,
    input  logic [data_w-1:0] in_imm,
    input  logic              in_src2_is_imm,
    output logic              out_valid,
    input  logic              out_allowin,
    output logic [data_w-1:0] out_result,
    output logic              out_overflow,
    output logic              out_addr_error,
    output logic              mem_req,
    output logic              mem_wr,
    output logic [1:0]        mem_size,
    output logic [data_w-1:0] mem_addr,
    output logic [3:0]        mem_wstrb,
    output logic [data_w-1:0] mem_wdata,
    input  logic              mem_addr_ok
);

    function automatic logic writes_hilo(alu_op_e op);
        return op inside {alu_mult, alu_multu, alu_div, alu_divu, alu_mthi, alu_mtlo};
    endfunction

    logic              stage_valid;
    alu_op_e           op_r;
    mem_op_e           mem_op_r;
    logic [data_w-1:0] rs_r;
    logic [data_w-1:0] rt_r;
    logic [data_w-1:0] imm_r;
    logic              src2_is_imm_r;
    logic [data_w-1:0] src2;
    logic [data_w-1:0] alu_result;
    logic              alu_overflow;
    logic [data_w-1:0] hi;
    logic [data_w-1:0] lo;
    logic              md_busy;
    logic              md_start;
    logic              commit;
    logic              accept;
    logic              out_fire;
    logic              ready_go;
    logic              req_r;

    assign accept   = in_valid && in_allowin;
    assign out_fire = out_valid && out_allowin;

    // stage register holds one instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (in_allowin) begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_r          <= in_op;
            mem_op_r      <= in_mem_op;
            rs_r          <= in_rs;
            rt_r          <= in_rt;
            imm_r         <= in_imm;
            src2_is_imm_r <= in_src2_is_imm;
        end
    end

    assign src2 = src2_is_imm_r ? imm_r : rt_r;

    exe_alu alu_i (
        .op       (op_r),
        .a        (rs_r),
        .b        (src2),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    // muldiv samples the incoming operands on the accepting edge
    assign md_start = accept && writes_hilo(in_op);
    assign commit   = out_fire && writes_hilo(op_r) && !out_overflow;

    exe_muldiv muldiv_i (
        .clk    (clk),
        .reset  (reset),
        .start  (md_start),
        .commit (commit),
        .op     (in_op),
        .a      (in_rs),
        .b      (in_rt),
        .busy   (md_busy),
        .hi     (hi),
        .lo     (lo)
    );

    exe_store_align align_i (
        .mem_op     (mem_op_r),
        .addr       (alu_result),
        .rt         (rt_r),
        .phys_addr  (mem_addr),
        .size       (mem_size),
        .wstrb      (mem_wstrb),
        .wdata      (mem_wdata),
        .addr_error (out_addr_error)
    );

    // request raised on accept and dropped once the address is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            req_r <= 1'b0;
        end else if (accept) begin
            req_r <= (in_mem_op != mem_none);
        end else if (mem_addr_ok) begin
            req_r <= 1'b0;
        end
    end

    assign mem_req = req_r && !out_addr_error;
    assign mem_wr  = mem_op_r inside {mem_store_byte, mem_store_half, mem_store_word,
                                      mem_store_left, mem_store_right};

    // a running division or a pending request holds the stage
    assign ready_go   = !md_busy && !mem_req;
    assign out_valid  = stage_valid && ready_go;
    assign in_allowin = !stage_valid || (ready_go && out_allowin);

    always_comb begin
        case (op_r)
            alu_mfhi: out_result = hi;
            alu_mflo: out_result = lo;
            alu_mthi, alu_mtlo: begin
                out_result = rs_r;
            end
            alu_mult, alu_multu, alu_div, alu_divu: begin
                out_result = '0;
            end
            default:  out_result = alu_result;
        endcase
    end

    assign out_overflow = alu_overflow;

    assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr) && $stable(mem_wdata)
            && $stable(mem_wstrb));

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin |=> out_valid && $stable(out_result));

endmodule

`default_nettype wire

/* hw/exe_store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_store_align import exe_pkg::*; (
    input  mem_op_e           mem_op,
    input  logic [data_w-1:0] addr,
    input  logic [data_w-1:0] rt,
    output logic [data_w-1:0] phys_addr,
    output logic [1:0]        size,
    output logic [3:0]        wstrb,
    output logic [data_w-1:0] wdata,
    output logic              addr_error
);

    logic [1:0] off;

    assign off = addr[1:0];

    // top nibble 8..b means kseg0 or kseg1, unmapped
    assign phys_addr = (addr[data_w-1 -: 2] == 2'b10) ? (addr & kseg_mask) : addr;

    always_comb begin
        size       = size_word;
        wstrb      = 4'b0000;
        wdata      = rt;
        addr_error = 1'b0;
        case (mem_op)
            mem_store_byte: begin
                size  = size_byte;
                wstrb = 4'b0001 << off;
                wdata = {4{rt[7:0]}};
            end
            mem_store_half: begin
                size       = size_half;
                wstrb      = 4'b0011 << off;
                wdata      = {2{rt[15:0]}};
                addr_error = off[0];
            end
            mem_store_word: begin
                wstrb      = 4'b1111;
                addr_error = (off != 2'b00);
            end
            mem_store_left: begin
                // low bytes up to the addressed one
                wdata = rt >> {~off, 3'b000};
                case (off)
                    2'd0:    begin size = size_byte; wstrb = 4'b0001; end
                    2'd1:    begin size = size_half; wstrb = 4'b0011; end
                    2'd2:    begin size = size_word; wstrb = 4'b0111; end
                    default: begin size = size_word; wstrb = 4'b1111; end
                endcase
            end
            mem_store_right: begin
                // addressed byte up to the top
                wdata = rt << {off, 3'b000};
                case (off)
                    2'd0:    begin size = size_word; wstrb = 4'b1111; end
                    2'd1:    begin size = size_word; wstrb = 4'b1110; end
                    2'd2:    begin size = size_half; wstrb = 4'b1100; end
                    default: begin size = size_byte; wstrb = 4'b1000; end
                endcase
            end
            // loads and none keep zero strobes
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* sim/exe_cases.hex */
// op mem_op rs rt imm src2 | result overflow addr_error | size wstrb addr wdata
// request columns are the expected memory fields, zero where no request is made
14 0 cafef00d 00000000 00000000 0 cafef00d 0 0 0 0 00000000 00000000
00 0 7fffffff 00000001 00000000 0 80000000 1 0 0 0 00000000 00000000
12 0 00000000 00000000 00000000 0 cafef00d 0 0 0 0 00000000 00000000
01 0 ffffffff 00000002 00000000 0 00000001 0 0 0 0 00000000 00000000
02 0 80000000 00000001 00000000 0 7fffffff 1 0 0 0 00000000 00000000
03 0 00000000 00000001 00000000 0 ffffffff 0 0 0 0 00000000 00000000
08 0 ffffffff 00000001 00000000 0 00000001 0 0 0 0 00000000 00000000
09 0 ffffffff 00000001 00000000 0 00000000 0 0 0 0 00000000 00000000
0c 0 00000004 80000010 00000000 0 f8000001 0 0 0 0 00000000 00000000
0a 0 00000008 00000000 000000ff 1 0000ff00 0 0 0 0 00000000 00000000
0d 0 00000000 00000000 00001234 1 12340000 0 0 0 0 00000000 00000000
0e 0 fffffffe 00000003 00000000 0 00000000 0 0 0 0 00000000 00000000
12 0 00000000 00000000 00000000 0 ffffffff 0 0 0 0 00000000 00000000
10 0 fffffff9 00000002 00000000 0 00000000 0 0 0 0 00000000 00000000
13 0 00000000 00000000 00000000 0 fffffffd 0 0 0 0 00000000 00000000
10 0 00000007 fffffffe 00000000 0 00000000 0 0 0 0 00000000 00000000
12 0 00000000 00000000 00000000 0 00000001 0 0 0 0 00000000 00000000
11 0 80000000 00000003 00000000 0 00000000 0 0 0 0 00000000 00000000
13 0 00000000 00000000 00000000 0 2aaaaaaa 0 0 0 0 00000000 00000000
0f 0 ffffffff ffffffff 00000000 0 00000000 0 0 0 0 00000000 00000000
12 0 00000000 00000000 00000000 0 fffffffe 0 0 0 0 00000000 00000000
15 0 12345678 00000000 00000000 0 12345678 0 0 0 0 00000000 00000000
13 0 00000000 00000000 00000000 0 12345678 0 0 0 0 00000000 00000000
01 2 00001000 aabbcc44 00000001 1 00001001 0 0 0 2 00001001 44444444
01 2 00001000 aabbcc44 00000003 1 00001003 0 0 0 8 00001003 44444444
01 3 a0002000 11225566 00000002 1 a0002002 0 0 1 c 00002002 55665566
01 3 00002000 11225566 00000001 1 00002001 0 1 0 0 00000000 00000000
01 4 80004000 deadbeef 00000004 1 80004004 0 0 2 f 00004004 deadbeef
01 4 80004000 deadbeef 00000002 1 80004002 0 1 0 0 00000000 00000000
01 1 c0000010 00000000 00000000 1 c0000010 0 0 2 0 c0000010 00000000
01 5 00003000 11223344 00000000 1 00003000 0 0 0 1 00003000 00000011
01 5 00003000 11223344 00000001 1 00003001 0 0 1 3 00003001 00001122
01 5 00003000 11223344 00000002 1 00003002 0 0 2 7 00003002 00112233
01 5 00003000 11223344 00000003 1 00003003 0 0 2 f 00003003 11223344
01 6 00003000 11223344 00000000 1 00003000 0 0 2 f 00003000 11223344
01 6 00003000 11223344 00000001 1 00003001 0 0 2 e 00003001 22334400
01 6 00003000 11223344 00000002 1 00003002 0 0 1 c 00003002 33440000
01 6 00003000 11223344 00000003 1 00003003 0 0 0 8 00003003 44000000

/* sim/exe_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_checker import exe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  int                case_idx,
    input  mem_op_e           exp_mem_op,
    input  logic [data_w-1:0] exp_result,
    input  logic              exp_overflow,
    input  logic              exp_addr_error,
    input  logic [1:0]        exp_size,
    input  logic [3:0]        exp_wstrb,
    input  logic [data_w-1:0] exp_addr,
    input  logic [data_w-1:0] exp_wdata,
    input  logic              in_valid,
    input  logic              in_allowin,
    input  logic              out_valid,
    input  logic              out_allowin,
    input  logic [data_w-1:0] out_result,
    input  logic              out_overflow,
    input  logic              out_addr_error,
    input  logic              mem_req,
    input  logic              mem_wr,
    input  logic [1:0]        mem_size,
    input  logic [data_w-1:0] mem_addr,
    input  logic [3:0]        mem_wstrb,
    input  logic [data_w-1:0] mem_wdata,
    input  logic              mem_addr_ok,
    output int                pass_count,
    output int                fail_count
);

    logic                  out_hold;
    logic                  req_hold;
    logic                  case_bad;
    logic                  exp_wr;
    logic                  need_req;
    logic                  occupied;
    logic [data_w-1:0]     held_result;
    logic [2*data_w+6:0]   held_req;
    int                    req_count;
    int                    xfer_count;

    // only store ops write
    assign exp_wr   = (exp_mem_op != mem_none) && (exp_mem_op != mem_load_word);
    assign need_req = (exp_mem_op != mem_none) && !exp_addr_error;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch in test %0d on %s: got %h, expected %h",
                     case_idx, name, got, expected);
            case_bad = 1'b1;
        end
    endtask

    task automatic check_request();
        req_count++;
        if (!need_req) begin
            $display("test %0d raised a memory request it should not have", case_idx);
            case_bad = 1'b1;
        end else if (req_count > 1) begin
            $display("test %0d raised more than one memory request", case_idx);
            case_bad = 1'b1;
        end
        compare_field("mem_wr", mem_wr, exp_wr);
        compare_field("mem_size", mem_size, exp_size);
        compare_field("mem_wstrb", mem_wstrb, exp_wstrb);
        compare_field("mem_addr", mem_addr, exp_addr);
        compare_field("mem_wdata", mem_wdata, exp_wdata);
    endtask

    task automatic finish_case();
        if (xfer_count != case_idx) begin
            $display("test %0d left the stage out of order, transfer number %0d",
                     case_idx, xfer_count);
            case_bad = 1'b1;
        end
        if (need_req && req_count == 0) begin
            $display("test %0d finished without its memory request", case_idx);
            case_bad = 1'b1;
        end
        compare_field("out_result", out_result, exp_result);
        compare_field("out_overflow", out_overflow, exp_overflow);
        compare_field("out_addr_error", out_addr_error, exp_addr_error);
        if (case_bad) begin
            fail_count++;
            $display("test %0d failed", case_idx);
        end else begin
            pass_count++;
            $display("test %0d passed", case_idx);
        end
        xfer_count++;
        req_count = 0;
        case_bad  = 1'b0;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            out_hold   = 1'b0;
            req_hold   = 1'b0;
            case_bad   = 1'b0;
            occupied   = 1'b0;
            req_count  = 0;
            xfer_count = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            // held output or request must not move until taken
            if (out_hold && (!out_valid || out_result !== held_result)) begin
                $display("test %0d: output dropped or changed before it was taken", case_idx);
                case_bad = 1'b1;
            end
            if (req_hold && (!mem_req ||
                    {mem_wr, mem_size, mem_addr, mem_wdata, mem_wstrb} !== held_req)) begin
                $display("test %0d: memory request dropped or changed before it was taken",
                         case_idx);
                case_bad = 1'b1;
            end
            // stage takes a new case only when empty or emptying
            compare_field("in_allowin", in_allowin, !occupied || (out_valid && out_allowin));
            occupied    = (in_valid && in_allowin) || (occupied && !(out_valid && out_allowin));
            out_hold    = out_valid && !out_allowin;
            held_result = out_result;
            req_hold    = mem_req && !mem_addr_ok;
            held_req    = {mem_wr, mem_size, mem_addr, mem_wdata, mem_wstrb};
            if (mem_req && mem_addr_ok) begin
                check_request();
            end
            if (out_valid && out_allowin) begin
                finish_case();
            end
        end
    end

endmodule

`default_nettype wire

/* sim/exe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_tb import exe_pkg::*; ();

    localparam int n_cases    = 38;
    localparam int n_fields   = 13;
    localparam int max_cycles = n_cases * (div_steps + 40);

    logic              clk;
    logic              reset;
    logic              in_valid;
    logic              in_allowin;
    alu_op_e           in_op;
    mem_op_e           in_mem_op;
    logic [data_w-1:0] in_rs;
    logic [data_w-1:0] in_rt;
    logic [data_w-1:0] in_imm;
    logic              in_src2_is_imm;
    logic              out_valid;
    logic              out_allowin;
    logic [data_w-1:0] out_result;
    logic              out_overflow;
    logic              out_addr_error;
    logic              mem_req;
    logic              mem_wr;
    logic [1:0]        mem_size;
    logic [data_w-1:0] mem_addr;
    logic [3:0]        mem_wstrb;
    logic [data_w-1:0] mem_wdata;
    logic              mem_addr_ok;

    logic [31:0]       case_mem [0:n_cases*n_fields-1];
    int                case_idx;
    int                cycles = 0;
    int                pass_count;
    int                fail_count;
    logic [15:0]       lfsr;

    always #5 clk = ~clk;

    exe_stage dut_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_allowin     (in_allowin),
        .in_op          (in_op),
        .in_mem_op      (in_mem_op),
        .in_rs          (in_rs),
        .in_rt          (in_rt),
        .in_imm         (in_imm),
        .in_src2_is_imm (in_src2_is_imm),
        .out_valid      (out_valid),
        .out_allowin    (out_allowin),
        .out_result     (out_result),
        .out_overflow   (out_overflow),
        .out_addr_error (out_addr_error),
        .mem_req        (mem_req),
        .mem_wr         (mem_wr),
        .mem_size       (mem_size),
        .mem_addr       (mem_addr),
        .mem_wstrb      (mem_wstrb),
        .mem_wdata      (mem_wdata),
        .mem_addr_ok    (mem_addr_ok)
    );

    exe_checker checker_i (
        .clk            (clk),
        .reset          (reset),
        .case_idx       (case_idx),
        .exp_mem_op     (mem_op_e'(case_mem[case_idx*n_fields + 1][2:0])),
        .exp_result     (case_mem[case_idx*n_fields + 6]),
        .exp_overflow   (case_mem[case_idx*n_fields + 7][0]),
        .exp_addr_error (case_mem[case_idx*n_fields + 8][0]),
        .exp_size       (case_mem[case_idx*n_fields + 9][1:0]),
        .exp_wstrb      (case_mem[case_idx*n_fields + 10][3:0]),
        .exp_addr       (case_mem[case_idx*n_fields + 11]),
        .exp_wdata      (case_mem[case_idx*n_fields + 12]),
        .in_valid       (in_valid),
        .in_allowin     (in_allowin),
        .out_valid      (out_valid),
        .out_allowin    (out_allowin),
        .out_result     (out_result),
        .out_overflow   (out_overflow),
        .out_addr_error (out_addr_error),
        .mem_req        (mem_req),
        .mem_wr         (mem_wr),
        .mem_size       (mem_size),
        .mem_addr       (mem_addr),
        .mem_wstrb      (mem_wstrb),
        .mem_wdata      (mem_wdata),
        .mem_addr_ok    (mem_addr_ok),
        .pass_count     (pass_count),
        .fail_count     (fail_count)
    );

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    // one random bit each for sink and memory stalls
    task automatic update_backpressure();
        take_bit(out_allowin);
        take_bit(mem_addr_ok);
    endtask

    // offer one case and wait until it leaves the stage
    task automatic run_case(input int idx);
        int   base;
        logic taken;
        logic leaving;
        base           = idx * n_fields;
        case_idx       = idx;
        in_op          = alu_op_e'(case_mem[base][4:0]);
        in_mem_op      = mem_op_e'(case_mem[base + 1][2:0]);
        in_rs          = case_mem[base + 2];
        in_rt          = case_mem[base + 3];
        in_imm         = case_mem[base + 4];
        in_src2_is_imm = case_mem[base + 5][0];
        in_valid       = 1'b1;
        leaving        = 1'b0;
        while (!leaving) begin
            update_backpressure();
            // settle before looking at the handshakes
            #1;
            taken   = in_valid && in_allowin;
            leaving = out_valid && out_allowin;
            @(negedge clk);
            if (taken) begin
                in_valid = 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_op          = alu_add;
        in_mem_op      = mem_none;
        in_rs          = '0;
        in_rt          = '0;
        in_imm         = '0;
        in_src2_is_imm = 1'b0;
        out_allowin    = 1'b1;
        mem_addr_ok    = 1'b0;
        case_idx       = 0;
        lfsr           = 16'd51281;
        $readmemh("sim/exe_cases.hex", case_mem);
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        repeat (2) @(negedge clk);
        $display("%0d tests: %0d passed, %0d failed", n_cases, pass_count, fail_count);
        if (fail_count == 0 && pass_count == n_cases) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/exe_pkg.sv
hw/exe_alu.sv
hw/exe_muldiv.sv
hw/exe_store_align.sv
hw/exe_stage.sv
sim/exe_checker.sv
sim/exe_tb.sv
